//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_seq_monitor
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hw/seq_defines.svh
`ifndef SEQ_DEFINES_SVH
`define SEQ_DEFINES_SVH

// thread table depth
`define SEQ_MAX_THREADS 8

// index into the table
`define SEQ_IDX_W 3

// live thread count, 0 to SEQ_MAX_THREADS
`define SEQ_CNT_W 4

`endif

//--- hw/seq_monitor_top.sv
module seq_monitor_top (
    input  logic gclk,
    input  logic sys_rst,
    input  logic sample_valid,
    input  logic c,
    input  logic b,
    output logic busy,
    output logic succ,
    output logic fail,
    output logic overflow
);

    thread_if tif ();

    walk_ctrl i_walk_ctrl (
        .gclk         (gclk),
        .sys_rst      (sys_rst),
        .sample_valid (sample_valid),
        .c            (c),
        .b            (b),
        .busy         (busy),
        .tif          (tif.ctrl)
    );

    thread_table i_thread_table (
        .gclk    (gclk),
        .sys_rst (sys_rst),
        .tif     (tif.tbl)
    );

    seq_stepper i_seq_stepper (
        .gclk    (gclk),
        .sys_rst (sys_rst),
        .succ    (succ),
        .fail    (fail),
        .tif     (tif.step)
    );

    // lines up with the succ and fail registers in the stepper
    always_ff @(posedge gclk or posedge sys_rst) begin
        if (sys_rst) begin
            overflow <= 1'b0;
        end else begin
            overflow <= tif.overflow;
        end
    end

endmodule

//--- hw/seq_prop_pkg.sv
package seq_prop_pkg;

    // consecutive samples with b low seen by a thread
    typedef enum logic [1:0] {
        run_zero = 2'd0,
        run_one  = 2'd1,
        run_two  = 2'd2
    } low_run_t;

    typedef struct packed {
        low_run_t low_run;
    } thread_rec_t;

endpackage

//--- hw/seq_stepper.sv
module seq_stepper (
    input  logic   gclk,
    input  logic   sys_rst,
    output logic   succ,
    output logic   fail,
    thread_if.step tif
);
    import seq_prop_pkg::*;

    thread_rec_t cur;
    thread_rec_t nxt;
    logic        act;
    logic        alive;
    logic        step_succ;
    logic        step_fail;
    logic        succ_acc;
    logic        fail_acc;

    assign act = tif.rd_valid || tif.spawn;

    // thread rule
    always_comb begin
        cur       = tif.spawn ? '{low_run: run_zero} : tif.rd_rec;
        nxt       = cur;
        alive     = 1'b0;
        step_succ = 1'b0;
        step_fail = 1'b0;
        if (!tif.sample.c) begin
            step_fail = 1'b1;
        end else if (cur.low_run == run_two) begin
            step_succ = 1'b1;
        end else begin
            alive = 1'b1;
            if (tif.sample.b) begin
                nxt.low_run = run_zero;
            end else if (cur.low_run == run_zero) begin
                nxt.low_run = run_one;
            end else begin
                nxt.low_run = run_two;
            end
        end
    end

    always_ff @(posedge gclk or posedge sys_rst) begin
        if (sys_rst) begin
            tif.wr_en <= 1'b0;
            succ_acc  <= 1'b0;
            fail_acc  <= 1'b0;
            succ      <= 1'b0;
            fail      <= 1'b0;
        end else begin
            tif.wr_en <= act && alive;  // dead threads are not written back
            if (tif.commit) begin
                succ     <= succ_acc;
                fail     <= fail_acc;
                succ_acc <= 1'b0;
                fail_acc <= 1'b0;
            end else begin
                succ <= 1'b0;
                fail <= 1'b0;
                if (act) begin
                    succ_acc <= succ_acc || step_succ;
                    fail_acc <= fail_acc || step_fail;
                end
            end
        end
    end

    always_ff @(posedge gclk) begin
        tif.wr_rec <= nxt;
    end

endmodule

//--- hw/seq_walk_pkg.sv
package seq_walk_pkg;

    typedef enum logic [1:0] {
        walk_idle   = 2'd0,
        walk_read   = 2'd1,  // reads, then one drain cycle
        walk_spawn  = 2'd2,
        walk_commit = 2'd3
    } walk_state_t;

    typedef struct packed {
        logic c;
        logic b;
    } sample_t;

endpackage

//--- hw/thread_if.sv
`include "seq_defines.svh"

interface thread_if;
    import seq_prop_pkg::*;
    import seq_walk_pkg::*;

    logic                  rd_en;
    logic [`SEQ_IDX_W-1:0] rd_idx;
    logic                  spawn;   // step a fresh run_zero record
    logic                  commit;
    sample_t               sample;
    logic [`SEQ_CNT_W-1:0] live_count;
    thread_rec_t           rd_rec;
    logic                  rd_valid;
    logic                  overflow;
    logic                  wr_en;
    thread_rec_t           wr_rec;

    modport ctrl (
        output rd_en,
        output rd_idx,
        output spawn,
        output commit,
        output sample,
        input  live_count
    );

    modport tbl (
        input  rd_en,
        input  rd_idx,
        input  commit,
        input  wr_en,
        input  wr_rec,
        output rd_rec,
        output rd_valid,
        output live_count,
        output overflow
    );

    modport step (
        input  rd_rec,
        input  rd_valid,
        input  spawn,
        input  commit,
        input  sample,
        output wr_en,
        output wr_rec
    );

endinterface

//--- hw/thread_table.sv
`include "seq_defines.svh"

module thread_table (
    input  logic  gclk,
    input  logic  sys_rst,
    thread_if.tbl tif
);
    import seq_prop_pkg::*;

    thread_rec_t           recs [`SEQ_MAX_THREADS];
    logic [`SEQ_CNT_W-1:0] wr_ptr;
    logic                  full;
    logic                  wr_ok;

    assign full  = (wr_ptr == `SEQ_CNT_W'(`SEQ_MAX_THREADS));
    assign wr_ok = tif.wr_en && !full;

    // only the spawn write-back can find the table full
    assign tif.overflow = tif.wr_en && full;

    always_ff @(posedge gclk or posedge sys_rst) begin
        if (sys_rst) begin
            tif.rd_valid   <= 1'b0;
            tif.live_count <= '0;
            wr_ptr         <= '0;
        end else begin
            tif.rd_valid <= tif.rd_en;
            if (tif.commit) begin
                // spawn write-back lands in the commit cycle
                tif.live_count <= wr_ok ? wr_ptr + 1'b1 : wr_ptr;
                wr_ptr         <= '0;
            end else if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // write pointer trails the read index, survivors pack toward slot 0
    always_ff @(posedge gclk) begin
        if (tif.rd_en) begin
            tif.rd_rec <= recs[tif.rd_idx];
        end
        if (wr_ok) begin
            recs[wr_ptr[`SEQ_IDX_W-1:0]] <= tif.wr_rec;
        end
    end

endmodule

//--- hw/walk_ctrl.sv
`include "seq_defines.svh"

module walk_ctrl (
    input  logic   gclk,
    input  logic   sys_rst,
    input  logic   sample_valid,
    input  logic   c,
    input  logic   b,
    output logic   busy,
    thread_if.ctrl tif
);
    import seq_walk_pkg::*;

    walk_state_t           state;
    logic [`SEQ_CNT_W-1:0] rd_cnt;
    logic                  accept;

    assign busy   = (state != walk_idle);
    assign accept = sample_valid && !busy;  // pulses while busy are dropped

    // live_count only moves on commit, so it stays N for the whole walk
    assign tif.rd_en  = (state == walk_read) && (rd_cnt != tif.live_count);
    assign tif.rd_idx = rd_cnt[`SEQ_IDX_W-1:0];
    assign tif.spawn  = (state == walk_spawn);
    assign tif.commit = (state == walk_commit);

    always_ff @(posedge gclk or posedge sys_rst) begin
        if (sys_rst) begin
            state  <= walk_idle;
            rd_cnt <= '0;
        end else begin
            case (state)
                walk_idle: begin
                    if (accept) begin
                        state  <= walk_read;
                        rd_cnt <= '0;
                    end
                end
                walk_read: begin
                    // the cycle after the last read lets its record reach the stepper
                    if (rd_cnt == tif.live_count) begin
                        state <= walk_spawn;
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                walk_spawn: begin
                    state <= walk_commit;
                end
                walk_commit: begin
                    state <= walk_idle;
                end
                default: begin
                    state <= walk_idle;
                end
            endcase
        end
    end

    // held for the stepper until the next acceptance
    always_ff @(posedge gclk) begin
        if (accept) begin
            tif.sample <= '{c: c, b: b};
        end
    end

endmodule

//--- src.f
+incdir+hw
hw/seq_prop_pkg.sv
hw/seq_walk_pkg.sv
hw/thread_if.sv
hw/walk_ctrl.sv
hw/thread_table.sv
hw/seq_stepper.sv
hw/seq_monitor_top.sv
tests/tb_seq_monitor.sv

//--- tests/seq_vectors.txt
# columns: c b exp_succ exp_fail exp_overflow stray
# stray 1 adds a sample_valid pulse with c low while the walk is busy
0 0 0 1 0 0
1 0 0 0 0 0
1 0 0 0 0 0
1 1 1 0 0 0
0 1 0 1 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 0 0 0 0 0
0 0 0 1 0 0
1 0 0 0 0 0
1 0 0 0 0 0
1 0 1 0 0 0
1 0 1 0 0 0
1 1 1 0 0 0
1 0 0 0 0 0
1 0 0 0 0 0
1 1 1 0 0 0
0 1 0 1 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 0 0
1 1 0 0 1 0
1 1 0 0 1 0
1 0 0 0 1 1
1 0 0 0 1 0
1 1 1 0 0 0
1 0 0 0 0 1
1 0 0 0 0 0
1 1 1 0 0 0
0 0 0 1 0 0

//--- tests/tb_seq_monitor.sv
`include "seq_defines.svh"

module tb_seq_monitor;

    localparam int clk_period = 4;
    localparam int busy_limit = `SEQ_MAX_THREADS + 8;  // cycles allowed for one walk

    logic gclk;
    logic sys_rst;
    logic sample_valid;
    logic c;
    logic b;
    logic busy;
    logic succ;
    logic fail;
    logic overflow;

    // one entry per vector line
    logic vec_c [$];
    logic vec_b [$];
    logic exp_succ [$];
    logic exp_fail [$];
    logic exp_ovf [$];
    logic vec_stray [$];

    int   num_vec;
    int   err_cnt;
    int   check_cnt;
    logic loaded;

    seq_monitor_top i_seq_monitor_top (
        .gclk         (gclk),
        .sys_rst      (sys_rst),
        .sample_valid (sample_valid),
        .c            (c),
        .b            (b),
        .busy         (busy),
        .succ         (succ),
        .fail         (fail),
        .overflow     (overflow)
    );

    initial begin
        gclk = 1'b0;
        forever #(clk_period / 2) gclk = ~gclk;
    end

    task automatic load_vectors();
        int                 fd;
        int                 n;
        int                 f_c, f_b, f_s, f_f, f_o, f_x;
        logic [8*128-1:0]   text;
        fd = $fopen("tests/seq_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/seq_vectors.txt");
            err_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            text = '0;
            n = $fgets(text, fd);
            if (n > 0) begin
                n = $sscanf(text, "%d %d %d %d %d %d", f_c, f_b, f_s, f_f, f_o, f_x);
                if (n == 6) begin  // comment lines give no numbers
                    vec_c.push_back(f_c[0]);
                    vec_b.push_back(f_b[0]);
                    exp_succ.push_back(f_s[0]);
                    exp_fail.push_back(f_f[0]);
                    exp_ovf.push_back(f_o[0]);
                    vec_stray.push_back(f_x[0]);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_output(input string ctx, input string name,
                                  input logic got, input logic want);
        check_cnt++;
        assert (got === want) else begin
            err_cnt++;
            $display("[FAIL] %0t: %s, %s is %b, expected %b", $time, ctx, name, got, want);
        end
    endtask

    task automatic wait_walk_end(input int idx, output logic done);
        int    cycles;
        string ctx;
        ctx    = $sformatf("vector %0d while busy", idx);
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < busy_limit) begin
            if (!busy) begin
                done = 1'b1;
            end else begin
                // results only pulse in the cycle busy falls
                compare_output(ctx, "succ", succ, 1'b0);
                compare_output(ctx, "fail", fail, 1'b0);
                compare_output(ctx, "overflow", overflow, 1'b0);
                @(negedge gclk);
                cycles++;
            end
        end
        if (!done) begin
            err_cnt++;
            $display("busy did not fall within %0d cycles on vector %0d", busy_limit, idx);
        end
    endtask

    task automatic run_vector(input int idx);
        string ctx;
        logic  done;
        ctx = $sformatf("vector %0d", idx);
        @(negedge gclk);
        c            = vec_c[idx];
        b            = vec_b[idx];
        sample_valid = 1'b1;
        @(negedge gclk);
        sample_valid = 1'b0;
        compare_output(ctx, "busy", busy, 1'b1);
        if (vec_stray[idx]) begin
            // walk is running so this pulse must be dropped
            c            = 1'b0;
            sample_valid = 1'b1;
            @(negedge gclk);
            sample_valid = 1'b0;
        end
        wait_walk_end(idx, done);
        if (done) begin
            compare_output(ctx, "succ", succ, exp_succ[idx]);
            compare_output(ctx, "fail", fail, exp_fail[idx]);
            compare_output(ctx, "overflow", overflow, exp_ovf[idx]);
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = num_vec * (`SEQ_MAX_THREADS + 4) * clk_period;
        limit = limit + limit / 2 + 50 * clk_period;  // reset and stray pulses
        #(limit);
        err_cnt++;
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        sys_rst      = 1'b1;
        sample_valid = 1'b0;
        c            = 1'b0;
        b            = 1'b0;
        err_cnt      = 0;
        check_cnt    = 0;
        loaded       = 1'b0;
        load_vectors();
        num_vec = vec_c.size();
        loaded  = 1'b1;
        repeat (5) @(negedge gclk);
        sys_rst = 1'b0;
        @(negedge gclk);
        compare_output("after reset", "busy", busy, 1'b0);
        compare_output("after reset", "succ", succ, 1'b0);
        compare_output("after reset", "fail", fail, 1'b0);
        compare_output("after reset", "overflow", overflow, 1'b0);
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        repeat (2) @(negedge gclk);
        if (num_vec == 0) begin
            err_cnt++;
            $display("no vectors were read from the file");
        end
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
